//--- common/huff_pkg.sv
package huff_pkg;

    localparam int num_syms  = 256;  // leaves sit at 0..255
    localparam int num_nodes = 511;  // leaves plus at most 255 merged nodes

    typedef logic [8:0] node_idx_t;

    // entry 0 is a leaf and never a parent, so 0 in a parent field marks the root
    localparam node_idx_t no_parent = 9'd0;

    typedef enum logic [2:0] {
        ph_idle     = 3'd0,
        ph_clear    = 3'd1,
        ph_hist     = 3'd2,
        ph_flv      = 3'd3,
        ph_htree    = 3'd4,
        ph_codebook = 3'd5,
        ph_done     = 3'd6
    } huff_phase_t;

    // one word of the node memory
    typedef struct packed {
        logic        live;    // still a merge candidate
        node_idx_t   parent;
        logic [31:0] weight;  // byte count or sum of children
        node_idx_t   left;
        node_idx_t   right;
        logic [3:0]  spare;
    } node_t;

endpackage

//--- common/sram_pkg.sv
package sram_pkg;

    localparam int mem_addr_bits = 9;

    typedef struct packed {
        logic                     we;     // write when set, read otherwise
        logic [mem_addr_bits-1:0] addr;
        logic [63:0]              wdata;
    } mem_req_t;

    typedef struct packed {
        logic        done;   // one-cycle completion
        logic [63:0] rdata;  // valid with done
    } mem_rsp_t;

endpackage

//--- verilog/huff_ctrl.sv
module huff_ctrl import huff_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic        hist_fin,
    input  logic        flv_fin,
    input  logic        flv_end,
    input  logic        htree_fin,
    input  logic        cb_fin,
    output huff_phase_t phase,
    output logic        clear_go,
    output logic        flv_go,
    output logic        htree_go,
    output logic        cb_go,
    output logic        busy,
    output logic        done
);

    assign busy = (phase != ph_idle) && (phase != ph_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= ph_idle;
            clear_go <= 1'b0;
            flv_go   <= 1'b0;
            htree_go <= 1'b0;
            cb_go    <= 1'b0;
            done     <= 1'b0;
        end else begin
            clear_go <= 1'b0;
            flv_go   <= 1'b0;
            htree_go <= 1'b0;
            cb_go    <= 1'b0;
            done     <= 1'b0;
            case (phase)
                ph_idle, ph_done: begin
                    phase <= ph_idle;
                    if (start) begin
                        phase    <= ph_clear;
                        clear_go <= 1'b1;
                    end
                end
                // hist_counter pulses fin once after clearing, once after the last byte
                ph_clear: if (hist_fin) phase <= ph_hist;
                ph_hist: begin
                    if (hist_fin) begin
                        phase  <= ph_flv;
                        flv_go <= 1'b1;
                    end
                end
                ph_flv: begin
                    if (flv_end) begin
                        phase <= ph_codebook;  // only the root is left
                        cb_go <= 1'b1;
                    end else if (flv_fin) begin
                        phase    <= ph_htree;
                        htree_go <= 1'b1;
                    end
                end
                ph_htree: begin
                    if (htree_fin) begin
                        phase  <= ph_flv;
                        flv_go <= 1'b1;
                    end
                end
                ph_codebook: begin
                    if (cb_fin) begin
                        phase <= ph_done;
                        done  <= 1'b1;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

endmodule

//--- verilog/sram_interface.sv
module sram_interface import huff_pkg::*, sram_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  huff_phase_t phase,
    input  mem_req_t    hist_req,
    input  mem_req_t    flv_req,
    input  mem_req_t    ht_req,
    input  mem_req_t    cb_req,
    input  logic        hist_stb,
    input  logic        flv_stb,
    input  logic        ht_stb,
    input  logic        cb_stb,
    output mem_req_t    mem_req,
    output logic        mem_stb,
    input  logic [63:0] rdata_raw,
    output mem_rsp_t    rsp
);

    typedef enum logic [1:0] {s_idle, s_wait1, s_wait2} ctrl_state_t;

    ctrl_state_t ctrl_state;
    mem_req_t    sel_req;
    logic        sel_stb;
    logic        busy;
    logic        done_q;
    logic [63:0] rdata_q;

    assign busy = (ctrl_state != s_idle) || done_q;  // strobe+1 .. strobe+3
    assign rsp  = {done_q, rdata_q};

    // owner of the memory in each phase
    always_comb begin
        case (phase)
            ph_clear, ph_hist: begin
                sel_req = hist_req;
                sel_stb = hist_stb;
            end
            ph_flv: begin
                sel_req = flv_req;
                sel_stb = flv_stb;
            end
            ph_htree: begin
                sel_req = ht_req;
                sel_stb = ht_stb;
            end
            ph_codebook: begin
                sel_req = cb_req;
                sel_stb = cb_stb;
            end
            default: begin
                sel_req = hist_req;
                sel_stb = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_state <= s_idle;
            mem_stb    <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            mem_stb <= 1'b0;
            done_q  <= 1'b0;
            case (ctrl_state)
                s_idle: begin
                    if (sel_stb && !busy) begin
                        ctrl_state <= s_wait1;
                        mem_stb    <= 1'b1;  // sram access in wait1
                    end
                end
                s_wait1: ctrl_state <= s_wait2;
                s_wait2: begin
                    ctrl_state <= s_idle;
                    done_q     <= 1'b1;
                end
                default: ctrl_state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_state == s_idle && sel_stb && !busy)
            mem_req <= sel_req;
        if (ctrl_state == s_wait2)
            rdata_q <= rdata_raw;  // registered sram output lands here
    end

    // clients hold off until their done pulse
    a_stb_while_busy: assert property (@(posedge clk) disable iff (rst)
        sel_stb |-> !busy)
        else $error("memory request while interface busy");

endmodule

//--- verilog/node_sram.sv
module node_sram import huff_pkg::*, sram_pkg::*; (
    input  logic        clk,
    input  mem_req_t    mem_req,
    input  logic        mem_stb,
    output logic [63:0] rdata_raw
);

    node_t mem [0:num_nodes];  // contents undefined until the clear phase

    always_ff @(posedge clk) begin
        if (mem_stb) begin
            if (mem_req.we)
                mem[mem_req.addr] <= mem_req.wdata;
            else
                rdata_raw <= mem[mem_req.addr];
        end
    end

endmodule

//--- histogram/hist_counter.sv
module hist_counter import huff_pkg::*, sram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear_go,
    input  logic       byte_valid,
    input  logic       byte_last,
    input  logic [7:0] byte_data,
    output mem_req_t   req,
    output logic       req_stb,
    input  mem_rsp_t   rsp,
    output logic       hist_busy,
    output logic       hist_fin
);

    typedef enum logic [2:0] {s_idle, s_clr_wait, s_byte, s_rd_wait, s_wr_wait} hist_state_t;

    hist_state_t state;
    node_idx_t   clr_addr;
    logic [7:0]  sym;
    logic        last_q;
    logic        stb_q;
    node_t       rd_node;
    node_t       wr_node;

    assign rd_node   = node_t'(rsp.rdata);
    assign hist_busy = (state != s_idle) && (state != s_byte);

    // the read for a new byte goes out in the strobe cycle itself
    always_comb begin
        if (state == s_byte && byte_valid) begin
            req_stb = 1'b1;
            req     = '{we: 1'b0, addr: {1'b0, byte_data}, wdata: '0};
        end else if (state == s_wr_wait) begin
            req_stb = stb_q;
            req     = '{we: 1'b1, addr: {1'b0, sym}, wdata: wr_node};
        end else begin
            req_stb = stb_q;
            req     = '{we: 1'b1, addr: clr_addr, wdata: '0};  // clearing
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= s_idle;
            clr_addr <= '0;
            stb_q    <= 1'b0;
            hist_fin <= 1'b0;
        end else begin
            stb_q    <= 1'b0;
            hist_fin <= 1'b0;
            case (state)
                s_idle: begin
                    if (clear_go) begin
                        state    <= s_clr_wait;
                        clr_addr <= '0;
                        stb_q    <= 1'b1;
                    end
                end
                s_clr_wait: begin
                    if (rsp.done) begin
                        clr_addr <= clr_addr + 9'd1;
                        if (clr_addr == num_nodes) begin
                            hist_fin <= 1'b1;  // clear finished
                            state    <= s_byte;
                        end else begin
                            stb_q <= 1'b1;
                        end
                    end
                end
                s_byte: if (byte_valid) state <= s_rd_wait;
                s_rd_wait: begin
                    if (rsp.done) begin
                        stb_q <= 1'b1;  // write back the new count
                        state <= s_wr_wait;
                    end
                end
                s_wr_wait: begin
                    if (rsp.done) begin
                        if (last_q) begin
                            hist_fin <= 1'b1;
                            state    <= s_idle;
                        end else begin
                            state <= s_byte;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_byte && byte_valid) begin
            sym    <= byte_data;
            last_q <= byte_last;
        end
        if (state == s_rd_wait && rsp.done) begin
            wr_node        <= rd_node;
            wr_node.live   <= 1'b1;
            wr_node.weight <= rd_node.weight + 32'd1;
        end
    end

    // sender has to wait for hist_busy low between bytes
    a_byte_while_busy: assert property (@(posedge clk) disable iff (rst)
        byte_valid |-> !hist_busy)
        else $error("byte strobe while histogram busy");

endmodule

//--- htree/flv_scan.sv
module flv_scan import huff_pkg::*, sram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flv_go,
    input  node_idx_t next_free,
    output mem_req_t  req,
    output logic      req_stb,
    input  mem_rsp_t  rsp,
    output logic      found,
    output node_idx_t first_idx,
    output node_idx_t second_idx,
    output node_t     first_node,
    output node_t     second_node,
    output logic      flv_end
);

    typedef enum logic {s_idle, s_wait} scan_state_t;

    scan_state_t state;
    node_idx_t   scan_idx;
    logic        have1;
    logic        have2;
    logic        take1;
    logic        take2;
    logic        pair_ok;
    node_t       cur;

    assign cur = node_t'(rsp.rdata);
    assign req = '{we: 1'b0, addr: scan_idx, wdata: '0};

    // strict compares keep the lower index on a tie, since the scan ascends
    assign take1   = cur.live && (!have1 || cur.weight < first_node.weight);
    assign take2   = cur.live && !take1 && (!have2 || cur.weight < second_node.weight);
    assign pair_ok = have2 || take2 || (take1 && have1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= s_idle;
            scan_idx <= '0;
            have1    <= 1'b0;
            have2    <= 1'b0;
            req_stb  <= 1'b0;
            found    <= 1'b0;
            flv_end  <= 1'b0;
        end else begin
            req_stb <= 1'b0;
            found   <= 1'b0;
            flv_end <= 1'b0;
            case (state)
                s_idle: begin
                    if (flv_go) begin
                        state    <= s_wait;
                        scan_idx <= '0;
                        have1    <= 1'b0;
                        have2    <= 1'b0;
                        req_stb  <= 1'b1;
                    end
                end
                s_wait: begin
                    if (rsp.done) begin
                        have1 <= have1 || take1;
                        have2 <= pair_ok;
                        if (scan_idx == next_free - 9'd1) begin
                            state   <= s_idle;
                            found   <= pair_ok;
                            flv_end <= !pair_ok;  // root is the one live entry left
                        end else begin
                            scan_idx <= scan_idx + 9'd1;
                            req_stb  <= 1'b1;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // held after found until the builder has used them
    always_ff @(posedge clk) begin
        if (state == s_wait && rsp.done) begin
            if (take1) begin
                second_idx  <= first_idx;
                second_node <= first_node;
                first_idx   <= scan_idx;
                first_node  <= cur;
            end else if (take2) begin
                second_idx  <= scan_idx;
                second_node <= cur;
            end
        end
    end

endmodule

//--- htree/htree_builder.sv
module htree_builder import huff_pkg::*, sram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      htree_go,
    input  node_idx_t first_idx,
    input  node_idx_t second_idx,
    input  node_t     first_node,
    input  node_t     second_node,
    output mem_req_t  req,
    output logic      req_stb,
    input  mem_rsp_t  rsp,
    output node_idx_t next_free,
    output logic      htree_fin
);

    logic       active;
    logic [1:0] step;  // 0 new node, 1 first child, 2 second child
    node_idx_t  wr_addr;
    node_t      wr_node;

    always_comb begin
        wr_node = '0;
        case (step)
            2'd0: begin
                wr_addr        = next_free;
                wr_node.live   = 1'b1;
                wr_node.parent = no_parent;
                wr_node.weight = first_node.weight + second_node.weight;
                wr_node.left   = first_idx;
                wr_node.right  = second_idx;
            end
            2'd1: begin
                wr_addr        = first_idx;
                wr_node        = first_node;
                wr_node.live   = 1'b0;  // retired
                wr_node.parent = next_free;
            end
            default: begin
                wr_addr        = second_idx;
                wr_node        = second_node;
                wr_node.live   = 1'b0;
                wr_node.parent = next_free;
            end
        endcase
    end

    assign req = '{we: 1'b1, addr: wr_addr, wdata: wr_node};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            step      <= 2'd0;
            next_free <= node_idx_t'(num_syms);
            req_stb   <= 1'b0;
            htree_fin <= 1'b0;
        end else begin
            req_stb   <= 1'b0;
            htree_fin <= 1'b0;
            if (!active && htree_go) begin
                active  <= 1'b1;
                step    <= 2'd0;
                req_stb <= 1'b1;
            end else if (active && rsp.done) begin
                if (step == 2'd2) begin
                    active    <= 1'b0;
                    next_free <= next_free + 9'd1;
                    htree_fin <= 1'b1;
                end else begin
                    step    <= step + 2'd1;
                    req_stb <= 1'b1;
                end
            end
        end
    end

    // flv_scan only pairs while two live entries remain, so a merge always fits
    a_node_range: assert property (@(posedge clk) disable iff (rst)
        htree_go |-> (next_free >= num_syms) && (next_free < num_nodes))
        else $error("merge started with no free node entry");

endmodule

//--- codebook/code_length.sv
module code_length import huff_pkg::*, sram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cb_go,
    output mem_req_t   req,
    output logic       req_stb,
    input  mem_rsp_t   rsp,
    output logic       len_valid,
    output logic [7:0] len_sym,
    output logic [7:0] len_bits,
    output logic       cb_fin
);

    typedef enum logic {s_idle, s_wait} cb_state_t;

    cb_state_t  state;
    logic [7:0] sym;
    node_idx_t  rd_addr;
    logic       at_leaf;
    logic [7:0] hops;
    node_t      cur;

    assign cur = node_t'(rsp.rdata);
    assign req = '{we: 1'b0, addr: rd_addr, wdata: '0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= s_idle;
            sym       <= '0;
            rd_addr   <= '0;
            at_leaf   <= 1'b0;
            hops      <= '0;
            req_stb   <= 1'b0;
            len_valid <= 1'b0;
            len_sym   <= '0;
            len_bits  <= '0;
            cb_fin    <= 1'b0;
        end else begin
            req_stb   <= 1'b0;
            len_valid <= 1'b0;
            cb_fin    <= 1'b0;
            case (state)
                s_idle: begin
                    if (cb_go) begin
                        state   <= s_wait;
                        sym     <= '0;
                        rd_addr <= '0;
                        at_leaf <= 1'b1;
                        hops    <= '0;
                        req_stb <= 1'b1;
                    end
                end
                s_wait: begin
                    if (rsp.done) begin
                        if (!(at_leaf && cur.weight == '0) && cur.parent != no_parent) begin
                            hops    <= hops + 8'd1;  // one more level up
                            rd_addr <= cur.parent;
                            at_leaf <= 1'b0;
                            req_stb <= 1'b1;
                        end else begin
                            if (!(at_leaf && cur.weight == '0)) begin
                                len_valid <= 1'b1;  // reached the root
                                len_sym   <= sym;
                                len_bits  <= hops;
                            end
                            if (sym == 8'd255) begin
                                state  <= s_idle;
                                cb_fin <= 1'b1;
                            end else begin
                                sym     <= sym + 8'd1;
                                rd_addr <= {1'b0, sym + 8'd1};
                                at_leaf <= 1'b1;
                                hops    <= '0;
                                req_stb <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

//--- verilog/huff_top.sv
module huff_top import huff_pkg::*, sram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       byte_valid,
    input  logic       byte_last,
    input  logic [7:0] byte_data,
    output logic       busy,
    output logic       hist_busy,
    output logic       len_valid,
    output logic [7:0] len_sym,
    output logic [7:0] len_bits,
    output logic       done
);

    huff_phase_t phase;
    logic        clear_go;
    logic        flv_go;
    logic        htree_go;
    logic        cb_go;
    logic        hist_fin;
    logic        found;
    logic        flv_end;
    logic        htree_fin;
    logic        cb_fin;

    mem_req_t    hist_req;
    mem_req_t    flv_req;
    mem_req_t    ht_req;
    mem_req_t    cb_req;
    logic        hist_stb;
    logic        flv_stb;
    logic        ht_stb;
    logic        cb_stb;
    mem_req_t    mem_req;
    logic        mem_stb;
    logic [63:0] rdata_raw;
    mem_rsp_t    rsp;

    node_idx_t   next_free;
    node_idx_t   first_idx;
    node_idx_t   second_idx;
    node_t       first_node;
    node_t       second_node;

    huff_ctrl huff_ctrl_i (
        .clk, .rst, .start, .hist_fin,
        .flv_fin (found),
        .flv_end, .htree_fin, .cb_fin, .phase,
        .clear_go, .flv_go, .htree_go, .cb_go, .busy, .done
    );

    hist_counter hist_counter_i (
        .clk, .rst, .clear_go, .byte_valid, .byte_last, .byte_data,
        .req (hist_req), .req_stb (hist_stb), .rsp, .hist_busy, .hist_fin
    );

    flv_scan flv_scan_i (
        .clk, .rst, .flv_go, .next_free,
        .req (flv_req), .req_stb (flv_stb), .rsp,
        .found, .first_idx, .second_idx, .first_node, .second_node, .flv_end
    );

    // node counter restarts at the first internal index with every run
    htree_builder htree_builder_i (
        .clk,
        .rst (rst | clear_go),
        .htree_go, .first_idx, .second_idx, .first_node, .second_node,
        .req (ht_req), .req_stb (ht_stb), .rsp, .next_free, .htree_fin
    );

    code_length code_length_i (
        .clk, .rst, .cb_go,
        .req (cb_req), .req_stb (cb_stb), .rsp,
        .len_valid, .len_sym, .len_bits, .cb_fin
    );

    sram_interface sram_interface_i (
        .clk, .rst, .phase,
        .hist_req, .flv_req, .ht_req, .cb_req,
        .hist_stb, .flv_stb, .ht_stb, .cb_stb,
        .mem_req, .mem_stb, .rdata_raw, .rsp
    );

    node_sram node_sram_i (
        .clk, .mem_req, .mem_stb, .rdata_raw
    );

endmodule

//--- testbench/huff_tb.sv
module huff_tb import huff_pkg::*; ();

    logic       clk;
    logic       rst;
    logic       start;
    logic       byte_valid;
    logic       byte_last;
    logic [7:0] byte_data;
    logic       busy;
    logic       hist_busy;
    logic       len_valid;
    logic [7:0] len_sym;
    logic [7:0] len_bits;
    logic       done;

    int          seed = 1;
    logic [7:0]  msg [$];      // message of the current run
    int          exp_sym [$];  // used symbols, ascending
    int          exp_len [$];
    int unsigned ref_w [0:num_nodes-1];
    bit          ref_live [0:num_nodes-1];
    int          ref_par [0:num_nodes-1];

    huff_top huff_top_i (
        .clk, .rst, .start, .byte_valid, .byte_last, .byte_data,
        .busy, .hist_busy, .len_valid, .len_sym, .len_bits, .done
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // lightest live entry below limit with ties going to the lowest index
    function automatic int lightest(input int limit, input int skip);
        int best;
        best = -1;
        for (int i = 0; i < limit; i++) begin
            if (ref_live[i] && i != skip) begin
                if (best < 0 || ref_w[i] < ref_w[best])
                    best = i;
            end
        end
        return best;
    endfunction

    // histogram, merges from 256 upward, then depth of every used leaf
    function automatic void build_expected();
        int nxt;
        int a;
        int b;
        int n;
        int d;
        for (int i = 0; i < num_nodes; i++) begin
            ref_w[i]    = 0;
            ref_live[i] = 1'b0;
            ref_par[i]  = 0;
        end
        foreach (msg[k]) begin
            ref_w[msg[k]]++;
            ref_live[msg[k]] = 1'b1;
        end
        nxt = num_syms;
        a = lightest(nxt, -1);
        b = lightest(nxt, a);
        while (b >= 0) begin
            ref_w[nxt]    = ref_w[a] + ref_w[b];
            ref_live[nxt] = 1'b1;
            ref_live[a]   = 1'b0;
            ref_live[b]   = 1'b0;
            ref_par[a]    = nxt;
            ref_par[b]    = nxt;
            nxt++;
            a = lightest(nxt, -1);
            b = lightest(nxt, a);
        end
        exp_sym.delete();
        exp_len.delete();
        for (int s = 0; s < num_syms; s++) begin
            if (ref_w[s] != 0) begin
                n = s;
                d = 0;
                while (ref_par[n] != 0) begin  // parent 0 marks the root
                    n = ref_par[n];
                    d++;
                end
                exp_sym.push_back(s);
                exp_len.push_back(d);
            end
        end
    endfunction

    // every length pulse must match the next used symbol
    always @(posedge clk) begin
        if (!rst && len_valid) begin
            if (exp_sym.size() == 0) begin
                $display("unexpected code length pulse for symbol %0d at time %0t",
                         len_sym, $time);
                $display("tests failed");
                $fatal(1, "extra output pulse");
            end else begin
                check_value("len_sym", int'(len_sym), exp_sym[0]);
                check_value("len_bits", int'(len_bits), exp_len[0]);
                exp_sym.delete(0);
                exp_len.delete(0);
            end
        end
    end

    task automatic wait_hist(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (hist_busy != level && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (hist_busy != level) begin
            $display("timeout: hist_busy did not reach %0d during %s", level, what);
            $display("tests failed");
            $fatal(1, "histogram wait timed out");
        end
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!done && cycles < limit) begin
            check_value("busy during run", int'(busy), 1);
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: no done pulse within %0d cycles", limit);
            $display("tests failed");
            $fatal(1, "run did not finish");
        end
    endtask

    task automatic send_byte(input logic [7:0] value, input logic last);
        byte_valid <= 1'b1;
        byte_data  <= value;
        byte_last  <= last;
        @(posedge clk);
        byte_valid <= 1'b0;
        byte_last  <= 1'b0;
        wait_hist(1'b0, 20, "byte update");  // read plus write back
    endtask

    task automatic feed_message();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_hist(1'b1, 10, "clear start");
        wait_hist(1'b0, 5000, "memory clear");
        for (int i = 0; i < msg.size(); i++)
            send_byte(msg[i], i == msg.size() - 1);
    endtask

    task automatic run_message(input string name);
        build_expected();
        $display("run %s: %0d bytes, %0d used symbols", name, msg.size(), exp_sym.size());
        feed_message();
        wait_done(2000000);
        check_value("lengths not seen", exp_sym.size(), 0);
    endtask

    task automatic check_idle_outputs(input string when);
        check_value({"busy ", when}, int'(busy), 0);
        check_value({"hist_busy ", when}, int'(hist_busy), 0);
        check_value({"len_valid ", when}, int'(len_valid), 0);
        check_value({"done ", when}, int'(done), 0);
    endtask

    task automatic make_random(input int n_bytes, input int n_syms);
        logic [7:0] pool [$];
        logic [7:0] pick;
        int         rnd;
        bit         dup;
        msg.delete();
        while (pool.size() < n_syms) begin
            rnd  = $random(seed);
            pick = rnd[7:0];
            dup  = 1'b0;
            foreach (pool[i])
                if (pool[i] == pick) dup = 1'b1;
            if (!dup)
                pool.push_back(pick);
        end
        for (int i = 0; i < n_bytes; i++) begin
            rnd = $random(seed);
            msg.push_back(pool[(rnd & 32'h7fffffff) % n_syms]);
        end
    endtask

    task automatic add_bytes(input logic [7:0] value, input int count);
        for (int i = 0; i < count; i++)
            msg.push_back(value);
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        byte_valid = 1'b0;
        byte_last  = 1'b0;
        byte_data  = 8'h00;
        repeat (3) @(posedge clk);
        check_idle_outputs("after reset");
        rst <= 1'b0;
        @(posedge clk);

        make_random(200, 20);
        run_message("random");
        msg.delete();
        add_bytes(8'd65, 5);
        add_bytes(8'd200, 3);
        run_message("two symbols");
        msg.delete();
        add_bytes(8'h7e, 12);
        run_message("one symbol");
        msg.delete();
        for (int s = num_syms - 1; s >= 0; s--)
            msg.push_back(s[7:0]);
        run_message("all symbols");
        msg.delete();
        for (int i = 0; i < 9; i++)
            add_bytes(8'(20 + 7 * i), 1 << i);  // doubling counts
        run_message("skewed");
        msg.delete();
        add_bytes(8'd20, 1);  // same symbols as the skewed run
        add_bytes(8'd27, 1);
        add_bytes(8'd34, 2);
        run_message("stale counts");

        // a run cut off by reset during tree building expects no lengths
        make_random(200, 20);
        exp_sym.delete();
        exp_len.delete();
        feed_message();
        repeat (200) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_idle_outputs("during reset");
        @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        make_random(200, 20);
        run_message("after reset");

        $display("all tests passed");
        $finish;
    end

endmodule

//--- compile.f
common/huff_pkg.sv
common/sram_pkg.sv
verilog/huff_ctrl.sv
verilog/sram_interface.sv
verilog/node_sram.sv
histogram/hist_counter.sv
htree/flv_scan.sv
htree/htree_builder.sv
codebook/code_length.sv
verilog/huff_top.sv
testbench/huff_tb.sv

//--- Makefile
TOP = huff_tb

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
